// File: design/pipe_input_queue.sv
// Per-pipe result FIFO, PIPE_CREDITS entries deep, with no ready signal
// Sender must hold a credit for every ex_val; a push into a full queue is undefined
// One registered credit_return pulse follows each pop

`timescale 1ns/1ps

module pipe_input_queue (
  input  logic             clk,
  input  logic             reset,
  input  logic             ex_val,
  input  wbc_pkg::ex_msg_t ex_msg,
  input  logic             pop,
  output logic             not_empty,
  output wbc_pkg::ex_msg_t head,
  output logic             credit_return
);

  import wbc_pkg::*;

  // Storage and pointers
  ex_msg_t                   entries [PIPE_CREDITS];
  logic [QUEUE_PTR_BITS-1:0] wr_ptr;
  logic [QUEUE_PTR_BITS-1:0] rd_ptr;
  logic [QUEUE_CNT_BITS-1:0] count;

  logic do_push;
  logic do_pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [QUEUE_PTR_BITS-1:0] ptr_next(
    input logic [QUEUE_PTR_BITS-1:0] ptr
  );
    if (ptr == QUEUE_PTR_BITS'(PIPE_CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ---------------------------------------------------------------------
  // Push and pop qualification
  // ---------------------------------------------------------------------

  // Credits guarantee space, so every ex_val is taken
  assign do_push   = ex_val;
  // Ignore a pop against an empty queue
  assign do_pop    = pop && not_empty;

  assign not_empty = (count != '0);
  assign head      = entries[rd_ptr];

  // Payload write, no reset needed
  always_ff @(posedge clk) begin
    if (do_push) begin
      entries[wr_ptr] <= ex_msg;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      unique case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // One credit back to the pipe per released entry
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= do_pop;
    end
  end

endmodule

// File: design/reorder_buffer.sv
// Reorder buffer indexed directly by sequence number, one entry per number
// Relies on upstream never having more than ROB_DEPTH instructions in flight
// No flush or exception recovery; commit output is a valid-only notification

`timescale 1ns/1ps

module reorder_buffer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wb_val,
  input  wbc_pkg::complete_msg_t wb,
  input  wbc_pkg::word_t         wb_pc,
  input  wbc_pkg::phys_reg_t     wb_ppreg,
  output logic                   commit_val,
  output wbc_pkg::commit_msg_t   commit
);

  import wbc_pkg::*;

  // ---------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------

  // Commit fields per sequence number
  commit_msg_t          entries [ROB_DEPTH];
  // Written but not yet retired
  logic [ROB_DEPTH-1:0] entry_valid;

  // Oldest unretired sequence number
  seq_num_t    head_ptr;
  seq_num_t    head_next;
  seq_num_t    wr_idx;

  // Entry assembled from the completion and the ROB-only fields
  commit_msg_t wb_entry;

  // Head entry is done and may leave this cycle
  logic        retire;
  commit_msg_t head_entry;

  // ---------------------------------------------------------------------
  // Write port
  // ---------------------------------------------------------------------

  assign wr_idx = wb.seq_num;

  always_comb begin
    wb_entry.pc      = wb_pc;
    wb_entry.seq_num = wb.seq_num;
    wb_entry.waddr   = wb.waddr;
    wb_entry.wdata   = wb.wdata;
    wb_entry.wen     = wb.wen;
    // Previous mapping is what gets freed on commit
    wb_entry.ppreg   = wb_ppreg;
  end

  // Payload array, loaded on writeback only
  always_ff @(posedge clk) begin
    if (wb_val) begin
      entries[wr_idx] <= wb_entry;
    end
  end

  // ---------------------------------------------------------------------
  // Retirement
  // ---------------------------------------------------------------------

  assign head_entry = entries[head_ptr];
  assign retire     = entry_valid[head_ptr];

  // Depth equals the sequence space, so the natural wrap is modulo ROB_DEPTH
  assign head_next  = head_ptr + 1'b1;

  // Valid bits and head pointer
  // A write and a retire in one cycle always hit different entries
  always_ff @(posedge clk) begin
    if (reset) begin
      entry_valid <= '0;
      head_ptr    <= '0;
    end else begin
      if (retire) begin
        entry_valid[head_ptr] <= 1'b0;
        head_ptr              <= head_next;
      end
      if (wb_val) begin
        entry_valid[wr_idx] <= 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Commit register
  // ---------------------------------------------------------------------

  // Up to one commit per cycle, back to back when the next entry is ready
  always_ff @(posedge clk) begin
    if (reset) begin
      commit_val <= 1'b0;
    end else begin
      commit_val <= retire;
    end
  end

  // Commit payload held until the next retirement
  always_ff @(posedge clk) begin
    if (retire) begin
      commit <= head_entry;
    end
  end

endmodule

// File: design/wbc_pkg.sv
// Shared sizes, vector types and message formats for the writeback-commit unit
// Upstream keeps at most ROB_DEPTH instructions in flight, so seq numbers never alias
// ROB_DEPTH must equal 2**SEQ_BITS because the ROB is indexed directly by seq number

package wbc_pkg;

  // ---------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------

  localparam int NUM_PIPES    = 2;
  localparam int SEQ_BITS     = 3;
  localparam int ROB_DEPTH    = 8;
  localparam int PHYS_BITS    = 6;
  localparam int AREG_BITS    = 5;
  localparam int XLEN         = 32;

  // Queue depth per pipe, also the credit count each pipe starts with
  localparam int PIPE_CREDITS = 2;

  // Derived queue widths
  localparam int QUEUE_PTR_BITS = (PIPE_CREDITS > 1) ? $clog2(PIPE_CREDITS) : 1;
  localparam int QUEUE_CNT_BITS = $clog2(PIPE_CREDITS + 1);

  // ---------------------------------------------------------------------
  // Vector types
  // ---------------------------------------------------------------------

  typedef logic [SEQ_BITS-1:0]           seq_num_t;
  typedef logic [PHYS_BITS-1:0]          phys_reg_t;
  typedef logic [AREG_BITS-1:0]          arch_reg_t;
  typedef logic [XLEN-1:0]               word_t;
  typedef logic [$clog2(NUM_PIPES)-1:0]  pipe_idx_t;

  // ---------------------------------------------------------------------
  // Messages
  // ---------------------------------------------------------------------

  // Finished instruction from an execute pipe
  typedef struct packed {
    word_t     pc;
    seq_num_t  seq_num;
    arch_reg_t waddr;
    word_t     wdata;
    logic      wen;
    phys_reg_t preg;   // newly allocated physical reg
    phys_reg_t ppreg;  // previous mapping, freed at commit
  } ex_msg_t;

  // Writeback / wakeup notification
  typedef struct packed {
    seq_num_t  seq_num;
    arch_reg_t waddr;
    word_t     wdata;
    logic      wen;
    phys_reg_t preg;
  } complete_msg_t;

  // In-order retirement notification
  typedef struct packed {
    word_t     pc;
    seq_num_t  seq_num;
    arch_reg_t waddr;
    word_t     wdata;
    logic      wen;
    phys_reg_t ppreg;
  } commit_msg_t;

endpackage

// File: design/writeback_arbiter.sv
// Round-robin writeback select across the pipe queues, one result per cycle
// Completion outputs are registered and never stalled
// wb_val mirrors complete_val so completion and ROB write are one event

`timescale 1ns/1ps

module writeback_arbiter (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [wbc_pkg::NUM_PIPES-1:0]      not_empty,
  input  wbc_pkg::ex_msg_t                   heads [wbc_pkg::NUM_PIPES],
  output logic [wbc_pkg::NUM_PIPES-1:0]      pop,
  output logic                               complete_val,
  output wbc_pkg::complete_msg_t             complete,
  output logic                               wb_val,
  output wbc_pkg::word_t                     wb_pc,
  output wbc_pkg::phys_reg_t                 wb_ppreg
);

  import wbc_pkg::*;

  // Pipe with highest priority this cycle
  pipe_idx_t prio_ptr;
  pipe_idx_t grant_idx;
  logic      grant_any;
  ex_msg_t   sel_head;

  // ---------------------------------------------------------------------
  // Grant selection
  // ---------------------------------------------------------------------

  // Scan starting at prio_ptr, first non-empty queue wins
  always_comb begin
    int cand;
    grant_any = 1'b0;
    grant_idx = prio_ptr;
    for (int k = 0; k < NUM_PIPES; k++) begin
      cand = (int'(prio_ptr) + k) % NUM_PIPES;
      if (!grant_any && not_empty[cand]) begin
        grant_any = 1'b1;
        grant_idx = pipe_idx_t'(cand);
      end
    end
  end

  // One-hot pop to the granted queue
  always_comb begin
    pop = '0;
    if (grant_any) begin
      pop[grant_idx] = 1'b1;
    end
  end

  assign sel_head = heads[grant_idx];

  // Move priority just past the winner so the other pipe goes next
  always_ff @(posedge clk) begin
    if (reset) begin
      prio_ptr <= '0;
    end else if (grant_any) begin
      if (grant_idx == pipe_idx_t'(NUM_PIPES - 1)) begin
        prio_ptr <= '0;
      end else begin
        prio_ptr <= grant_idx + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Completion register
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      complete_val <= 1'b0;
    end else begin
      complete_val <= grant_any;
    end
  end

  // Payload only loads on a grant
  always_ff @(posedge clk) begin
    if (grant_any) begin
      complete.seq_num <= sel_head.seq_num;
      complete.waddr   <= sel_head.waddr;
      complete.wdata   <= sel_head.wdata;
      complete.wen     <= sel_head.wen;
      complete.preg    <= sel_head.preg;
      // Fields only the ROB needs
      wb_pc            <= sel_head.pc;
      wb_ppreg         <= sel_head.ppreg;
    end
  end

  // ROB write strobe is the completion itself
  assign wb_val = complete_val;

endmodule

// File: design/writeback_commit_unit.sv
// Top of the writeback-commit unit, two credit-fed pipe queues in
// Completion and commit are valid-only notifications, never back-pressured
// Each pipe starts with PIPE_CREDITS credits and regains one per credit_return

`timescale 1ns/1ps

module writeback_commit_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [wbc_pkg::NUM_PIPES-1:0] ex_val,
  input  wbc_pkg::ex_msg_t              ex_msg [wbc_pkg::NUM_PIPES],
  output logic [wbc_pkg::NUM_PIPES-1:0] credit_return,
  output logic                          complete_val,
  output wbc_pkg::complete_msg_t        complete,
  output logic                          commit_val,
  output wbc_pkg::commit_msg_t          commit
);

  import wbc_pkg::*;

  // Queue to arbiter
  logic [NUM_PIPES-1:0] q_not_empty;
  ex_msg_t              q_heads [NUM_PIPES];
  logic [NUM_PIPES-1:0] q_pop;

  // Arbiter to ROB
  logic      wb_val;
  word_t     wb_pc;
  phys_reg_t wb_ppreg;

  // ---------------------------------------------------------------------
  // Per-pipe input queues
  // ---------------------------------------------------------------------

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_queue
    pipe_input_queue u_pipe_input_queue (
      .clk           (clk),
      .reset         (reset),
      .ex_val        (ex_val[p]),
      .ex_msg        (ex_msg[p]),
      .pop           (q_pop[p]),
      .not_empty     (q_not_empty[p]),
      .head          (q_heads[p]),
      .credit_return (credit_return[p])
    );
  end

  // Writeback select and completion
  writeback_arbiter u_writeback_arbiter (
    .clk          (clk),
    .reset        (reset),
    .not_empty    (q_not_empty),
    .heads        (q_heads),
    .pop          (q_pop),
    .complete_val (complete_val),
    .complete     (complete),
    .wb_val       (wb_val),
    .wb_pc        (wb_pc),
    .wb_ppreg     (wb_ppreg)
  );

  // In-order retirement, watching the same completion
  reorder_buffer u_reorder_buffer (
    .clk        (clk),
    .reset      (reset),
    .wb_val     (wb_val),
    .wb         (complete),
    .wb_pc      (wb_pc),
    .wb_ppreg   (wb_ppreg),
    .commit_val (commit_val),
    .commit     (commit)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the writeback-commit testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module wbc_tb -f sources.f \
  --Mdir obj_dir -o wbc_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/wbc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: sources.f
design/wbc_pkg.sv
design/pipe_input_queue.sv
design/writeback_arbiter.sv
design/reorder_buffer.sv
design/writeback_commit_unit.sv
testbench/wbc_props.sv
testbench/wbc_tb.sv

// File: testbench/wbc_props.sv
// Port-level properties of the writeback-commit unit, bound into the top level
// Queue occupancy is rebuilt here from ex_val and the internal pop strobes

`timescale 1ns/1ps

module wbc_props (
  input logic                          clk,
  input logic                          reset,
  input logic [wbc_pkg::NUM_PIPES-1:0] ex_val,
  input logic [wbc_pkg::NUM_PIPES-1:0] pop,
  input logic [wbc_pkg::NUM_PIPES-1:0] credit_return,
  input logic                          complete_val,
  input logic                          commit_val,
  input wbc_pkg::commit_msg_t          commit
);

  import wbc_pkg::*;

  logic [NUM_PIPES-1:0][QUEUE_CNT_BITS-1:0] occupancy;
  seq_num_t last_seq;
  seq_num_t next_seq;
  logic     have_prev;

  // Entries held per queue
  always_ff @(posedge clk) begin
    if (reset) begin
      occupancy <= '0;
    end else begin
      for (int p = 0; p < NUM_PIPES; p++) begin
        occupancy[p] <= occupancy[p] + QUEUE_CNT_BITS'(ex_val[p]) - QUEUE_CNT_BITS'(pop[p]);
      end
    end
  end

  // Last retired seq, first commit must be 0
  always_ff @(posedge clk) begin
    if (reset) begin
      have_prev <= 1'b0;
      last_seq  <= '0;
    end else if (commit_val) begin
      have_prev <= 1'b1;
      last_seq  <= commit.seq_num;
    end
  end

  assign next_seq = have_prev ? seq_num_t'(last_seq + seq_num_t'(1)) : '0;

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_full
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      ex_val[p] |-> (occupancy[p] != QUEUE_CNT_BITS'(PIPE_CREDITS)))
      else $error("ex_val on pipe %0d while its queue is full", p);
  end

  a_quiet_in_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!complete_val && !commit_val && (credit_return == '0)))
    else $error("Output valid while reset is high");

  a_commit_in_order: assert property (@(posedge clk) disable iff (reset)
    commit_val |-> (commit.seq_num == next_seq))
    else $error("Commit seq %0d out of order", commit.seq_num);

endmodule

bind writeback_commit_unit wbc_props u_wbc_props (
  .clk           (clk),
  .reset         (reset),
  .ex_val        (ex_val),
  .pop           (q_pop),
  .credit_return (credit_return),
  .complete_val  (complete_val),
  .commit_val    (commit_val),
  .commit        (commit)
);

// File: testbench/wbc_tb.sv
// Table-driven testbench for the writeback-commit unit
// Sequence numbers run 0..15 unwrapped and fold into the 3-bit ROB index
// Sender tracks its own credits and keeps the in-flight window below ROB_DEPTH

`timescale 1ns/1ps

module wbc_tb;

  import wbc_pkg::*;

  localparam int NUM_ROWS   = 16;
  localparam int WAIT_LIMIT = 200;

  // One stimulus row, seq is the unwrapped number
  typedef struct packed {
    pipe_idx_t  pipe;
    logic [3:0] seq;
    arch_reg_t  waddr;
    logic       wen;
    logic [1:0] gap;
    word_t      wdata;
  } row_t;

  logic                 clk;
  logic                 reset;
  logic [NUM_PIPES-1:0] ex_val;
  ex_msg_t              ex_msg [NUM_PIPES];
  logic [NUM_PIPES-1:0] credit_return;
  logic                 complete_val;
  complete_msg_t        complete;
  logic                 commit_val;
  commit_msg_t          commit;

  // Stimulus table and scoreboards
  row_t   rows [NUM_ROWS];
  int     row_of_seq [NUM_ROWS];
  logic   completed [NUM_ROWS];
  int     pipe0_order [$];
  int     pipe1_order [$];
  int     row_count = 0;
  integer seed = 26;

  // Sender credit view
  int credits [NUM_PIPES];
  int sent [NUM_PIPES];
  int returned [NUM_PIPES];
  int sent_total = 0;
  int completions = 0;
  int commits_seen = 0;

  logic timed_out = 1'b0;
  int   completion_errors = 0;
  int   commit_errors = 0;
  int   credit_errors = 0;
  int   reset_errors = 0;
  int   timeouts = 0;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  writeback_commit_unit u_writeback_commit_unit (
    .clk           (clk),
    .reset         (reset),
    .ex_val        (ex_val),
    .ex_msg        (ex_msg),
    .credit_return (credit_return),
    .complete_val  (complete_val),
    .complete      (complete),
    .commit_val    (commit_val),
    .commit        (commit)
  );

  // ---------------------------------------------------------------------
  // Table helpers and expected values
  // ---------------------------------------------------------------------

  task automatic add_row(input int pipe, input int seq, input int waddr, input logic wen,
                         input int gap);
    rows[row_count].pipe  = pipe_idx_t'(pipe);
    rows[row_count].seq   = 4'(seq);
    rows[row_count].waddr = arch_reg_t'(waddr);
    rows[row_count].wen   = wen;
    rows[row_count].gap   = 2'(gap);
    rows[row_count].wdata = $random(seed);
    row_of_seq[seq]       = row_count;
    row_count++;
  endtask

  // pc, preg and ppreg follow from the unwrapped sequence number
  function automatic ex_msg_t row_msg(input int r);
    ex_msg_t m;
    m.pc      = word_t'(32'h1000 + 4 * int'(rows[r].seq));
    m.seq_num = seq_num_t'(rows[r].seq);
    m.waddr   = rows[r].waddr;
    m.wdata   = rows[r].wdata;
    m.wen     = rows[r].wen;
    m.preg    = phys_reg_t'(8 + int'(rows[r].seq));
    m.ppreg   = phys_reg_t'(40 + int'(rows[r].seq));
    return m;
  endfunction

  function automatic complete_msg_t expected_completion(input int r);
    ex_msg_t       m;
    complete_msg_t c;
    m         = row_msg(r);
    c.seq_num = m.seq_num;
    c.waddr   = m.waddr;
    c.wdata   = m.wdata;
    c.wen     = m.wen;
    c.preg    = m.preg;
    return c;
  endfunction

  function automatic commit_msg_t expected_commit(input int r);
    ex_msg_t     m;
    commit_msg_t c;
    m         = row_msg(r);
    c.pc      = m.pc;
    c.seq_num = m.seq_num;
    c.waddr   = m.waddr;
    c.wdata   = m.wdata;
    c.wen     = m.wen;
    c.ppreg   = m.ppreg;
    return c;
  endfunction

  // Credit held, window open and no alias with an unretired entry
  function automatic logic slot_ready(input int r);
    return credits[rows[r].pipe] > 0 && (sent_total - commits_seen) < ROB_DEPTH &&
           int'(rows[r].seq) < commits_seen + ROB_DEPTH;
  endfunction

  function automatic logic all_credits_back();
    for (int p = 0; p < NUM_PIPES; p++) begin
      if (credits[p] != PIPE_CREDITS) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // ---------------------------------------------------------------------
  // Sender
  // ---------------------------------------------------------------------

  task automatic wait_for_slot(input int r);
    int waited;
    waited = 0;
    while (!slot_ready(r) && !timed_out) begin
      @(posedge clk);
      ex_val <= '0;
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        timeouts++;
        $display("Timeout at %0t: row %0d never got a credit or a free reorder slot",
                 $time, r);
      end
    end
  endtask

  task automatic drive_row(input int r);
    int                   p;
    logic [NUM_PIPES-1:0] onehot;
    p         = int'(rows[r].pipe);
    onehot    = '0;
    onehot[p] = 1'b1;
    @(posedge clk);
    ex_val    <= onehot;
    ex_msg[p] <= row_msg(r);
    credits[p]--;
    sent[p]++;
    sent_total++;
    if (p == 0) begin
      pipe0_order.push_back(r);
    end else begin
      pipe1_order.push_back(r);
    end
  endtask

  task automatic drain_commits();
    int waited;
    waited = 0;
    while (!timed_out && !(commits_seen == NUM_ROWS && all_credits_back())) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        timeouts++;
        $display("Timeout at %0t: only %0d of %0d commits arrived", $time, commits_seen,
                 NUM_ROWS);
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // Output monitor, sampled mid-cycle
  // ---------------------------------------------------------------------

  always @(negedge clk) begin : monitor
    int r;
    int p;
    if (reset) begin
      assert (!complete_val && !commit_val && credit_return == '0) else begin
        reset_errors++;
        $display("** Error at %0t: output valid during reset", $time);
      end
    end else begin
      for (p = 0; p < NUM_PIPES; p++) begin
        if (credit_return[p]) begin
          credits[p]++;
          returned[p]++;
          assert (returned[p] <= sent[p] && credits[p] <= PIPE_CREDITS) else begin
            credit_errors++;
            $display("** Error at %0t: extra credit_return on pipe %0d", $time, p);
          end
        end
      end
      // Completion must be the oldest unfinished row of one pipe
      if (complete_val) begin
        r = -1;
        if (pipe0_order.size() > 0 &&
            seq_num_t'(rows[pipe0_order[0]].seq) == complete.seq_num) begin
          r = pipe0_order.pop_front();
        end else if (pipe1_order.size() > 0 &&
                     seq_num_t'(rows[pipe1_order[0]].seq) == complete.seq_num) begin
          r = pipe1_order.pop_front();
        end
        assert (r >= 0) else begin
          completion_errors++;
          $display("** Error at %0t: completion seq %0d fits no pipe's oldest row",
                   $time, complete.seq_num);
        end
        if (r >= 0) begin
          completions++;
          completed[rows[r].seq] = 1'b1;
          assert (complete == expected_completion(r)) else begin
            completion_errors++;
            $display("** Error at %0t: completion got %h expected %h", $time, complete,
                     expected_completion(r));
          end
        end
      end
      // Commits in unwrapped sequence order
      if (commit_val) begin
        assert (commits_seen < NUM_ROWS) else begin
          commit_errors++;
          $display("** Error at %0t: commit with nothing left to retire", $time);
        end
        if (commits_seen < NUM_ROWS) begin
          r = row_of_seq[commits_seen];
          assert (completed[commits_seen]) else begin
            commit_errors++;
            $display("** Error at %0t: seq %0d committed before completing", $time,
                     commits_seen);
          end
          assert (commit == expected_commit(r)) else begin
            commit_errors++;
            $display("** Error at %0t: commit got %h expected %h", $time, commit,
                     expected_commit(r));
          end
        end
        commits_seen++;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------

  initial begin : main
    int p;
    int total;
    reset  = 1'b1;
    ex_val = '0;
    for (p = 0; p < NUM_PIPES; p++) begin
      ex_msg[p]   = '0;
      credits[p]  = PIPE_CREDITS;
      sent[p]     = 0;
      returned[p] = 0;
    end
    for (p = 0; p < NUM_ROWS; p++) begin
      completed[p] = 1'b0;
    end
    // Pipe, seq, waddr, wen, gap; neighbours swapped so arrival is out of order
    add_row(1, 1, 5, 1'b1, 0);
    add_row(0, 0, 3, 1'b1, 0);
    add_row(0, 3, 7, 1'b1, 1);
    add_row(1, 2, 9, 1'b1, 0);
    add_row(0, 4, 11, 1'b1, 0);
    add_row(1, 6, 2, 1'b1, 0);
    add_row(0, 5, 0, 1'b0, 2);
    add_row(1, 7, 14, 1'b1, 0);
    add_row(0, 9, 21, 1'b1, 0);
    add_row(1, 8, 30, 1'b1, 1);
    add_row(0, 10, 6, 1'b0, 0);
    add_row(0, 11, 17, 1'b1, 0);
    add_row(1, 13, 25, 1'b1, 3);
    add_row(0, 12, 12, 1'b1, 0);
    add_row(1, 15, 31, 1'b1, 0);
    add_row(0, 14, 8, 1'b0, 0);

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      wait_for_slot(r);
      if (!timed_out) begin
        drive_row(r);
        repeat (int'(rows[r].gap)) begin
          @(posedge clk);
          ex_val <= '0;
        end
      end
    end
    @(posedge clk);
    ex_val <= '0;

    drain_commits();
    // Idle tail catches stray completions or commits
    repeat (8) @(posedge clk);

    assert (completions == NUM_ROWS) else begin
      completion_errors++;
      $display("** Error at %0t: %0d completions for %0d rows", $time, completions, NUM_ROWS);
    end
    for (p = 0; p < NUM_PIPES; p++) begin
      assert (returned[p] == sent[p] && credits[p] == PIPE_CREDITS) else begin
        credit_errors++;
        $display("** Error at %0t: pipe %0d sent %0d, got %0d credits back, holds %0d",
                 $time, p, sent[p], returned[p], credits[p]);
      end
    end

    total = completion_errors + commit_errors + credit_errors + reset_errors + timeouts;
    $display("Errors: completion %0d, commit %0d, credit %0d, reset %0d, timeout %0d",
             completion_errors, commit_errors, credit_errors, reset_errors, timeouts);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
